// ==== src/rv_core_pkg.sv ====
// rv_core shared widths, memory sizing and instruction/ALU/arbiter encodings
package rv_core_pkg;

    localparam int XLEN      = 32;            // data and byte address width
    localparam int MEM_WORDS = 256;           // unified RAM depth in words
    localparam int MEM_AW    = 8;             // word address width
    localparam int REG_AW    = 5;             // register index width

    // RV32 major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b                            // lui immediate straight through
    } alu_op_e;

    // listed in priority order, highest first
    typedef enum logic [1:0] {
        req_host,
        req_data,
        req_fetch
    } requester_e;

endpackage

// ==== src/unified_ram.sv ====
// unified_ram: single-port word memory shared by code and data, one-cycle read
`timescale 1ns/1ps
module unified_ram (
    input  logic                           clk,
    input  logic                           we_i,
    input  logic [rv_core_pkg::MEM_AW-1:0] addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   wdata_i,
    output logic [rv_core_pkg::XLEN-1:0]   rdata_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] mem_q [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];              // old data on a write cycle
    end

endmodule

// ==== src/mem_arbiter.sv ====
// mem arbiter giving host, data and fetch fixed-priority access to the RAM and steering read data back
`timescale 1ns/1ps
module mem_arbiter (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           host_req_i,
    input  logic                           host_we_i,
    input  logic [rv_core_pkg::MEM_AW-1:0] host_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   host_wdata_i,
    input  logic                           data_req_i,
    input  logic                           data_we_i,
    input  logic [rv_core_pkg::MEM_AW-1:0] data_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   data_wdata_i,
    input  logic                           fetch_req_i,
    input  logic                           fetch_we_i,
    input  logic [rv_core_pkg::MEM_AW-1:0] fetch_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   fetch_wdata_i,
    output logic                           host_gnt_o,
    output logic                           data_gnt_o,
    output logic                           fetch_gnt_o,
    output logic                           host_rvalid_o,
    output logic                           data_rvalid_o,
    output logic                           fetch_rvalid_o,
    output logic [rv_core_pkg::XLEN-1:0]   rdata_o,
    output logic                           ram_we_o,
    output logic [rv_core_pkg::MEM_AW-1:0] ram_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]   ram_wdata_o,
    input  logic [rv_core_pkg::XLEN-1:0]   ram_rdata_i
);
    import rv_core_pkg::*;

    requester_e sel;
    requester_e sel_q;
    logic       sel_valid;
    logic       sel_valid_q;

    always_comb begin
        sel_valid = 1'b1;
        sel       = req_fetch;
        if (host_req_i) sel = req_host;
        else if (data_req_i) sel = req_data;
        else if (!fetch_req_i) sel_valid = 1'b0;
    end

    assign host_gnt_o  = sel_valid && (sel == req_host);
    assign data_gnt_o  = sel_valid && (sel == req_data);
    assign fetch_gnt_o = sel_valid && (sel == req_fetch);

    assign ram_we_o    = (host_gnt_o && host_we_i) || (data_gnt_o && data_we_i) ||
                         (fetch_gnt_o && fetch_we_i);
    assign ram_addr_o  = (sel == req_host) ? host_addr_i :
                         (sel == req_data) ? data_addr_i : fetch_addr_i;
    assign ram_wdata_o = (sel == req_host) ? host_wdata_i :
                         (sel == req_data) ? data_wdata_i : fetch_wdata_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_valid_q <= 1'b0;
            sel_q       <= req_fetch;
        end else begin
            sel_valid_q <= sel_valid;
            sel_q       <= sel;                // owner of next cycle's read data
        end
    end

    assign host_rvalid_o  = sel_valid_q && (sel_q == req_host);
    assign data_rvalid_o  = sel_valid_q && (sel_q == req_data);
    assign fetch_rvalid_o = sel_valid_q && (sel_q == req_fetch);
    assign rdata_o        = ram_rdata_i;

    // a load or store kept waiting holds its request
    a_data_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_req_i && !data_gnt_o |=>
        data_req_i && $stable(data_addr_i) && $stable(data_we_i));

endmodule

// ==== src/fetch_unit.sv ====
// fetch_unit: PC, single outstanding instruction fetch and the fetch/decode register
`timescale 1ns/1ps
module fetch_unit (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           run_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic [rv_core_pkg::XLEN-1:0]   target_i,
    output logic                           req_o,
    output logic [rv_core_pkg::MEM_AW-1:0] addr_o,
    input  logic                           gnt_i,
    input  logic                           rvalid_i,
    input  logic [rv_core_pkg::XLEN-1:0]   rdata_i,
    output logic                           inst_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]   inst_o,
    output logic [rv_core_pkg::XLEN-1:0]   pc_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] fetch_pc_q;
    logic            inflight_q;
    logic            discard_q;
    logic            hold_valid_q;
    logic [XLEN-1:0] hold_inst_q;
    logic [XLEN-1:0] hold_pc_q;
    logic            fetch_go;
    logic            accept;

    // next fetch may go out in the cycle the previous word returns
    assign req_o    = run_i && !stall_i && !hold_valid_q && (!inflight_q || rvalid_i);
    assign addr_o   = pc_q[MEM_AW+1:2];
    assign fetch_go = req_o && gnt_i;
    assign accept   = rvalid_i && !discard_q && !flush_i; // wrong-path words dropped

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= '0;
            inflight_q   <= 1'b0;
            discard_q    <= 1'b0;
            inst_valid_o <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            if (fetch_go) inflight_q <= 1'b1;
            else if (rvalid_i) inflight_q <= 1'b0;

            if (flush_i) discard_q <= fetch_go || (inflight_q && !rvalid_i);
            else if (rvalid_i) discard_q <= 1'b0;

            if (flush_i) begin
                pc_q         <= target_i;
                inst_valid_o <= 1'b0;
                hold_valid_q <= 1'b0;
            end else begin
                if (fetch_go) pc_q <= pc_q + 32'd4;
                if (!stall_i) begin
                    inst_valid_o <= hold_valid_q || accept;
                    hold_valid_q <= 1'b0;
                end else if (accept) begin
                    hold_valid_q <= 1'b1;  // decode busy, park the word
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) fetch_pc_q <= pc_q;
        if (!stall_i) begin
            inst_o <= hold_valid_q ? hold_inst_q : rdata_i;
            pc_o   <= hold_valid_q ? hold_pc_q : fetch_pc_q;
        end else if (accept) begin
            hold_inst_q <= rdata_i;
            hold_pc_q   <= fetch_pc_q;
        end
    end

endmodule

// ==== src/decode_execute.sv ====
// decode_execute: decoder, register file with forwarding, ALU, branch resolve, EX/MEM register
`timescale 1ns/1ps
module decode_execute (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           stall_i,
    input  logic                           inst_valid_i,
    input  logic [rv_core_pkg::XLEN-1:0]   inst_i,
    input  logic [rv_core_pkg::XLEN-1:0]   pc_i,
    input  logic                           wb_en_i,
    input  logic [rv_core_pkg::REG_AW-1:0] wb_rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]   wb_data_i,
    input  logic                           fwd_valid_i,
    input  logic [rv_core_pkg::REG_AW-1:0] fwd_rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]   fwd_data_i,
    output logic                           flush_o,
    output logic [rv_core_pkg::XLEN-1:0]   target_o,
    output logic                           unknown_o,
    output logic                           ex_valid_o,
    output rv_core_pkg::opcode_e           ex_op_o,
    output logic [rv_core_pkg::REG_AW-1:0] ex_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]   ex_result_o,
    output logic [rv_core_pkg::XLEN-1:0]   ex_store_data_o,
    output logic [rv_core_pkg::XLEN-1:0]   ex_pc_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0]   regs_q [1 << REG_AW];
    opcode_e           opc;
    alu_op_e           alu_op;
    logic              known;
    logic              writes_rd;
    logic              taken;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [2:0]        funct3;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   src_b;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   alu_res;

    // youngest pending result wins over the committing one
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] idx);
        if (idx == '0) return '0;
        if (fwd_valid_i && fwd_rd_i == idx) return fwd_data_i;
        if (wb_en_i && wb_rd_i == idx) return wb_data_i;
        return regs_q[idx];
    endfunction

    assign opc    = opcode_e'(inst_i[6:0]);
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct3 = inst_i[14:12];
    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b  = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    always_comb begin
        op_a = read_reg(rs1);
        op_b = read_reg(rs2);
    end

    always_comb begin
        alu_op    = alu_add;
        src_b     = imm_i;
        known     = 1'b1;
        writes_rd = 1'b1;
        case (opc)
            opc_op_imm, opc_op: begin
                if (opc == opc_op) src_b = op_b;
                case (funct3)
                    3'b000:  alu_op = (opc == opc_op && inst_i[30]) ? alu_sub : alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: known = 1'b0;        // shifts, sltu
                endcase
                if (opc == opc_op && (inst_i[31:25] & 7'b1011111) != '0) known = 1'b0;
            end
            opc_lui: begin
                alu_op = alu_pass_b;
                src_b  = {inst_i[31:12], 12'b0};
            end
            opc_load: ;                           // rs1 + imm_i address
            opc_store: begin
                src_b     = imm_s;
                writes_rd = 1'b0;
            end
            opc_branch: begin
                writes_rd = 1'b0;
                known     = (funct3[2:1] == 2'b00); // beq, bne
            end
            opc_system: begin
                writes_rd = 1'b0;
                known     = (inst_i == 32'h0010_0073); // ebreak only
            end
            default: begin
                known     = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_sub:    alu_res = op_a - src_b;
            alu_and:    alu_res = op_a & src_b;
            alu_or:     alu_res = op_a | src_b;
            alu_xor:    alu_res = op_a ^ src_b;
            alu_slt:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            alu_pass_b: alu_res = src_b;
            default:    alu_res = op_a + src_b;
        endcase
    end

    assign taken    = (op_a == op_b) ^ funct3[0];
    assign flush_o  = inst_valid_i && !stall_i && known && (opc == opc_branch) && taken;
    assign target_o = pc_i + imm_b;

    always_ff @(posedge clk) begin
        if (wb_en_i) regs_q[wb_rd_i] <= wb_data_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
            unknown_o  <= 1'b0;
        end else begin
            unknown_o <= inst_valid_i && !stall_i && !known; // dropped as a no-op
            if (!stall_i) ex_valid_o <= inst_valid_i && known;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_op_o         <= opc;
            ex_rd_o         <= writes_rd ? inst_i[11:7] : '0;
            ex_result_o     <= (writes_rd || opc == opc_store) ? alu_res : '0;
            ex_store_data_o <= op_b;
            ex_pc_o         <= pc_i;
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_en_i |-> wb_rd_i != '0);

endmodule

// ==== src/mem_writeback.sv ====
// mem_writeback: load/store sequencing, register write-back, commit trace and halt
`timescale 1ns/1ps
module mem_writeback (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           ex_valid_i,
    input  rv_core_pkg::opcode_e           ex_op_i,
    input  logic [rv_core_pkg::REG_AW-1:0] ex_rd_i,
    input  logic [rv_core_pkg::XLEN-1:0]   ex_result_i,
    input  logic [rv_core_pkg::XLEN-1:0]   ex_store_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]   ex_pc_i,
    output logic                           req_o,
    output logic                           we_o,
    output logic [rv_core_pkg::MEM_AW-1:0] addr_o,
    output logic [rv_core_pkg::XLEN-1:0]   wdata_o,
    input  logic                           gnt_i,
    input  logic                           rvalid_i,
    input  logic [rv_core_pkg::XLEN-1:0]   rdata_i,
    output logic                           stall_o,
    output logic                           wb_en_o,
    output logic [rv_core_pkg::REG_AW-1:0] wb_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]   wb_data_o,
    output logic                           fwd_valid_o,
    output logic [rv_core_pkg::REG_AW-1:0] fwd_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]   fwd_data_o,
    output logic                           commit_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]   commit_pc_o,
    output logic [rv_core_pkg::REG_AW-1:0] commit_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]   commit_data_o,
    output logic                           halted_o
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wait_gnt, st_wait_data} mem_state_e;

    mem_state_e      state_q;
    logic            live;
    logic            is_mem;
    logic            mem_done;
    logic            retire;
    logic [XLEN-1:0] result;

    assign live     = ex_valid_i && !halted_o;    // nothing past ebreak retires
    assign is_mem   = (ex_op_i == opc_load) || (ex_op_i == opc_store);
    assign mem_done = (state_q == st_wait_data) && rvalid_i;
    assign retire   = live && (!is_mem || mem_done);
    assign result   = (ex_op_i == opc_load) ? rdata_i : ex_result_i;

    assign req_o   = live && is_mem && (state_q != st_wait_data);
    assign we_o    = (ex_op_i == opc_store);
    assign addr_o  = ex_result_i[MEM_AW+1:2];      // word aligned only
    assign wdata_o = ex_store_data_i;
    assign stall_o = live && is_mem && !mem_done;

    assign fwd_valid_o = retire && (ex_rd_i != '0);
    assign fwd_rd_o    = ex_rd_i;
    assign fwd_data_o  = result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= st_idle;
            commit_valid_o <= 1'b0;
            halted_o       <= 1'b0;
        end else begin
            case (state_q)
                st_idle:     if (req_o) state_q <= gnt_i ? st_wait_data : st_wait_gnt;
                st_wait_gnt: if (gnt_i) state_q <= st_wait_data;
                default:     if (rvalid_i) state_q <= st_idle;
            endcase
            commit_valid_o <= retire;
            if (retire && ex_op_i == opc_system) halted_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_pc_o   <= ex_pc_i;
            commit_rd_o   <= ex_rd_i;                // zero for stores and branches
            commit_data_o <= (ex_op_i == opc_store) ? ex_store_data_i : result;
        end
    end

    // register file written in the commit cycle
    assign wb_en_o   = commit_valid_o && (commit_rd_o != '0);
    assign wb_rd_o   = commit_rd_o;
    assign wb_data_o = commit_data_o;

endmodule

// ==== src/rv_core_top.sv ====
// rv_core_top: three-stage RV32I-subset core with unified RAM and host load port
`timescale 1ns/1ps
module rv_core_top (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           run_i,
    input  logic                           host_req_i,
    input  logic                           host_we_i,
    input  logic [rv_core_pkg::MEM_AW-1:0] host_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]   host_wdata_i,
    output logic [rv_core_pkg::XLEN-1:0]   host_rdata_o,
    output logic                           host_rvalid_o,
    output logic                           commit_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]   commit_pc_o,
    output logic [rv_core_pkg::REG_AW-1:0] commit_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]   commit_data_o,
    output logic                           halted_o,
    output logic                           unknown_o
);
    import rv_core_pkg::*;

    logic              fetch_run;
    logic              fetch_req, fetch_gnt, fetch_rvalid;
    logic [MEM_AW-1:0] fetch_addr;
    logic              data_req, data_we, data_gnt, data_rvalid;
    logic [MEM_AW-1:0] data_addr;
    logic [XLEN-1:0]   data_wdata;
    logic [XLEN-1:0]   bus_rdata;
    logic              ram_we;
    logic [MEM_AW-1:0] ram_addr;
    logic [XLEN-1:0]   ram_wdata, ram_rdata;
    logic              stall, flush;
    logic [XLEN-1:0]   target;
    logic              inst_valid;
    logic [XLEN-1:0]   inst, inst_pc;
    logic              ex_valid;
    opcode_e           ex_op;
    logic [REG_AW-1:0] ex_rd, wb_rd, fwd_rd;
    logic [XLEN-1:0]   ex_result, ex_store_data, ex_pc;
    logic              wb_en, fwd_valid;
    logic [XLEN-1:0]   wb_data, fwd_data;

    assign fetch_run    = run_i && !halted_o;    // ebreak stops fetching
    assign host_rdata_o = bus_rdata;

    unified_ram u_ram (
        .clk(clk), .we_i(ram_we), .addr_i(ram_addr), .wdata_i(ram_wdata),
        .rdata_o(ram_rdata)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .arst_n_i(arst_n_i),
        .host_req_i(host_req_i), .host_we_i(host_we_i),
        .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
        .data_req_i(data_req), .data_we_i(data_we),
        .data_addr_i(data_addr), .data_wdata_i(data_wdata),
        .fetch_req_i(fetch_req), .fetch_we_i(1'b0),
        .fetch_addr_i(fetch_addr), .fetch_wdata_i('0),
        .host_gnt_o(), .data_gnt_o(data_gnt), .fetch_gnt_o(fetch_gnt),
        .host_rvalid_o(host_rvalid_o), .data_rvalid_o(data_rvalid),
        .fetch_rvalid_o(fetch_rvalid), .rdata_o(bus_rdata),
        .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
        .ram_rdata_i(ram_rdata)
    );

    fetch_unit u_fetch (
        .clk(clk), .arst_n_i(arst_n_i), .run_i(fetch_run),
        .stall_i(stall), .flush_i(flush), .target_i(target),
        .req_o(fetch_req), .addr_o(fetch_addr), .gnt_i(fetch_gnt),
        .rvalid_i(fetch_rvalid), .rdata_i(bus_rdata),
        .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(inst_pc)
    );

    decode_execute u_decode_execute (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall),
        .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(inst_pc),
        .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .fwd_valid_i(fwd_valid), .fwd_rd_i(fwd_rd), .fwd_data_i(fwd_data),
        .flush_o(flush), .target_o(target), .unknown_o(unknown_o),
        .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_rd_o(ex_rd),
        .ex_result_o(ex_result), .ex_store_data_o(ex_store_data), .ex_pc_o(ex_pc)
    );

    mem_writeback u_mem_writeback (
        .clk(clk), .arst_n_i(arst_n_i),
        .ex_valid_i(ex_valid), .ex_op_i(ex_op), .ex_rd_i(ex_rd),
        .ex_result_i(ex_result), .ex_store_data_i(ex_store_data), .ex_pc_i(ex_pc),
        .req_o(data_req), .we_o(data_we), .addr_o(data_addr), .wdata_o(data_wdata),
        .gnt_i(data_gnt), .rvalid_i(data_rvalid), .rdata_i(bus_rdata),
        .stall_o(stall), .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .fwd_valid_o(fwd_valid), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o),
        .halted_o(halted_o)
    );

endmodule

// ==== test/clk_gen.sv ====
// clk_gen: 4 ns testbench clock and an active-low reset held for 8 cycles
`timescale 1ns/1ps
module clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;            // 4 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;                     // release on a rising edge
    end

endmodule

// ==== test/tb_rv_core.sv ====
// tb_rv_core: loads a program through the host port, runs the core, checks trace and memory
`timescale 1ns/1ps
module tb_rv_core;
    import rv_core_pkg::*;

    localparam int STIM_WORDS        = 256;
    localparam int HDR_WORDS         = 3;    // program, commit and memory check counts
    localparam int CYCLES_PER_COMMIT = 40;
    localparam int QUIET_CYCLES      = 12;   // watch for stray commits after the halt
    localparam int READ_WAIT         = 8;

    logic              clk;
    logic              arst_n;
    logic              run;
    logic              host_req;
    logic              host_we;
    logic [MEM_AW-1:0] host_addr;
    logic [XLEN-1:0]   host_wdata;
    logic [XLEN-1:0]   host_rdata;
    logic              host_rvalid;
    logic              commit_valid;
    logic [XLEN-1:0]   commit_pc;
    logic [REG_AW-1:0] commit_rd;
    logic [XLEN-1:0]   commit_data;
    logic              halted;
    logic              unknown;

    logic [XLEN-1:0] stim [STIM_WORDS];
    int              n_prog;
    int              n_commit;
    int              n_mem;
    int              commit_base;
    int              mem_base;
    int              rec;
    int              watchdog_cycles = 0;
    int              commit_idx = 0;
    logic            loaded = 1'b0;
    logic            halt_seen = 1'b0;

    clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    rv_core_top uut (
        .clk(clk), .arst_n_i(arst_n), .run_i(run),
        .host_req_i(host_req), .host_we_i(host_we),
        .host_addr_i(host_addr), .host_wdata_i(host_wdata),
        .host_rdata_o(host_rdata), .host_rvalid_o(host_rvalid),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data),
        .halted_o(halted), .unknown_o(unknown)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR: t=%0t %s: got 0x%08h, expected 0x%08h",
                                        $time, what, got, exp));
        end
    endtask

    // addi x0, x0, <address>, so any stray fetch decodes as a no-op
    function automatic logic [XLEN-1:0] fill_word(input int addr);
        return {addr[11:0], 20'h00013};
    endfunction

    task automatic load_memory();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            @(posedge clk);
            host_req   <= 1'b1;
            host_we    <= 1'b1;
            host_addr  <= a[MEM_AW-1:0];
            host_wdata <= (a < n_prog) ? stim[HDR_WORDS + a] : fill_word(a);
        end
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic read_word(input int addr, output logic [XLEN-1:0] data);
        int   waited;
        logic got;
        data = '0;
        @(posedge clk);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= addr[MEM_AW-1:0];
        @(posedge clk);
        host_req <= 1'b0;                     // host always wins, granted this cycle
        got    = 1'b0;
        waited = 0;
        while (!got && waited < READ_WAIT) begin
            @(posedge clk);
            if (host_rvalid) begin
                data = host_rdata;
                got  = 1'b1;
            end
            waited++;
        end
        if (!got) begin
            stop_with_failure($sformatf("host read of word 0x%0h returned no data", addr));
        end
    endtask

    // commit trace checker, sampled at the rising edge
    always @(posedge clk) begin
        if (arst_n && loaded) begin
            check_value(32'(unknown), 32'd0, "unknown_o raised");
            if (halt_seen) check_value(32'(halted), 32'd1, "halted_o dropped after ebreak");
            if (halted && !halt_seen) begin
                check_value(32'(commit_valid), 32'd1, "halted_o without the ebreak commit");
            end
            if (commit_valid) begin
                if (halt_seen) stop_with_failure("the core committed an instruction after ebreak");
                if (commit_idx >= n_commit) begin
                    stop_with_failure("the core committed more instructions than expected");
                end
                rec = commit_base + 3 * commit_idx;
                check_value(commit_pc, stim[rec], $sformatf("commit %0d pc", commit_idx));
                check_value(32'(commit_rd), stim[rec + 1], $sformatf("commit %0d rd", commit_idx));
                check_value(commit_data, stim[rec + 2],
                            $sformatf("commit %0d data", commit_idx));
                commit_idx++;
            end
            if (halted) halt_seen = 1'b1;
        end
    end

    initial begin
        logic [XLEN-1:0] word;
        int              k;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        $readmemh("test/program_input.txt", stim);
        n_prog      = stim[0];
        n_commit    = stim[1];
        n_mem       = stim[2];
        commit_base = HDR_WORDS + n_prog;
        mem_base    = commit_base + 3 * n_commit;
        if (n_prog == 0 || n_prog > MEM_WORDS || n_commit == 0 ||
            mem_base + 2 * n_mem > STIM_WORDS) begin
            stop_with_failure("the stimulus file test/program_input.txt is missing or malformed");
        end
        watchdog_cycles = 16 + MEM_WORDS + CYCLES_PER_COMMIT * n_commit +
                          (READ_WAIT + 2) * n_mem + QUIET_CYCLES;
        loaded = 1'b1;

        @(posedge arst_n);
        @(posedge clk);
        check_value(32'({commit_valid, halted, unknown}), 32'd0, "outputs after reset");
        load_memory();
        @(posedge clk);
        run <= 1'b1;

        while (!halted) @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);
        check_value(commit_idx, n_commit, "number of commits");
        run <= 1'b0;                          // hand the RAM back to the host

        for (k = 0; k < n_mem; k++) begin
            read_word(stim[mem_base + 2 * k], word);
            check_value(word, stim[mem_base + 2 * k + 1],
                        $sformatf("memory word 0x%0h", stim[mem_base + 2 * k]));
        end
        $display("Done: no errors");
        $finish;
    end

    // watchdog sized from the file's counts
    initial begin
        while (watchdog_cycles == 0) @(posedge clk);
        repeat (watchdog_cycles) @(posedge clk);
        if (!halted) begin
            stop_with_failure("timeout: the core never halted");
        end else begin
            stop_with_failure("timeout: the memory readback never finished");
        end
    end

endmodule

// ==== test/program_input.txt ====
// hex words: program length, commit count, memory check count; then the program words,
// the commit records as pc rd data, and the memory checks as word address and value
14 11 03
00500093  // 00: addi x1, x0, 5
00708113  // 04: addi x2, x1, 7
002081b3  // 08: add  x3, x1, x2
40110233  // 0c: sub  x4, x2, x1
123452b7  // 10: lui  x5, 0x12345
0041c333  // 14: xor  x6, x3, x4
0020e3b3  // 18: or   x7, x1, x2
0033f433  // 1c: and  x8, x7, x3
002224b3  // 20: slt  x9, x4, x2
10302023  // 24: sw   x3, 256(x0)
10002503  // 28: lw   x10, 256(x0)
00150593  // 2c: addi x11, x10, 1
00350463  // 30: beq  x10, x3, +8
06300613  // 34: addi x12, x0, 99
00351463  // 38: bne  x10, x3, +8
00a59463  // 3c: bne  x11, x10, +8
04d00613  // 40: addi x12, x0, 77
10b02223  // 44: sw   x11, 260(x0)
00100073  // 48: ebreak
00100613  // 4c: addi x12, x0, 1
00000000 01 00000005
00000004 02 0000000c
00000008 03 00000011
0000000c 04 00000007
00000010 05 12345000
00000014 06 00000016
00000018 07 0000000d
0000001c 08 00000001
00000020 09 00000001
00000024 00 00000011  // store commits its data with rd 0
00000028 0a 00000011
0000002c 0b 00000012  // load result forwarded
00000030 00 00000000
00000038 00 00000000
0000003c 00 00000000
00000044 00 00000012
00000048 00 00000000
40 00000011
41 00000012
00 00500093

// ==== compile.f ====
src/rv_core_pkg.sv
src/unified_ram.sv
src/mem_arbiter.sv
src/fetch_unit.sv
src/decode_execute.sv
src/mem_writeback.sv
src/rv_core_top.sv
test/clk_gen.sv
test/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_TEXT  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
